/* verilog/bs_macros.svh */
/*
  Bank scheduler constants
  FIFO counts and depth, burst address width and write watermarks
*/
`ifndef BS_MACROS_SVH
`define BS_MACROS_SVH

// ********************************************************************
// FIFO arrangement
// ********************************************************************
`define BS_RD_FIFOS   4                        // Read FIFOs, global index 0..3
`define BS_WR_FIFOS   3                        // Write FIFOs, global index 4..6
`define BS_FIFOS      7                        // Read plus write
`define BS_FIFO_DEPTH 4                        // Entries per FIFO
`define BS_CNT_W      3                        // Holds 0..BS_FIFO_DEPTH

// ********************************************************************
// Request payload and watermarks
// ********************************************************************
`define BS_BURST_W    16                       // Burst (row) address width

// Write occupancy summed over all write FIFOs
`define BS_HIGH_WM    8                        // Enter write mode
`define BS_LOW_WM     2                        // Leave write mode

`endif

/* verilog/bs_pkg.sv */
/*
  Bank scheduler types
  Request, issue and per-FIFO status words shared across the subsystem
*/
`include "bs_macros.svh"

package bs_pkg;

  // ********************************************************************
  // Enqueue side
  // ********************************************************************
  typedef struct packed {
    logic                             is_write;  // 1 = write request
    logic [$clog2(`BS_RD_FIFOS)-1:0]  tid;       // Thread id, FIFO within its kind
    logic [`BS_BURST_W-1:0]           burst;     // Burst address
  } req_t;

  // ********************************************************************
  // Issue side, towards the arbiter
  // ********************************************************************
  typedef struct packed {
    logic [`BS_BURST_W-1:0]           burst;     // Burst address of the popped head
    logic [$clog2(`BS_FIFOS)-1:0]     fifo_idx;  // Global source FIFO
    logic                             is_write;  // Kind of the running burst
  } issue_t;

  // FIFO status, one per request FIFO
  typedef struct packed {
    logic                             empty;
    logic                             full;
    logic [`BS_CNT_W-1:0]             count;     // Entries held
  } fifo_stat_t;

endpackage

/* verilog/bs_enq_port.sv */
/*
  Enqueue port
  Four-phase req/ack receiver, routes each request to its FIFO by kind and thread
*/
`timescale 1ns/1ps
`include "bs_macros.svh"

module bs_enq_port (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_i,         // Four-phase request
  input  bs_pkg::req_t            enq_req_i,     // Held stable while req_i is high
  input  logic [`BS_FIFOS-1:0]    full_i,
  output logic                    ack_o,
  output logic [`BS_FIFOS-1:0]    push_o,        // One-hot push
  output logic [`BS_BURST_W-1:0]  push_burst_o   // Common write data
);
  localparam int IDX_W = $clog2(`BS_FIFOS);

  typedef enum logic [1:0] {IDLE, ACK, RELEASE} state_e;

  state_e            state_q, state_d;
  logic [IDX_W-1:0]  tgt;                        // Global target FIFO
  logic              accept;

  // Writes sit above the read FIFOs
  assign tgt = enq_req_i.is_write ? IDX_W'(`BS_RD_FIFOS) + IDX_W'(enq_req_i.tid)
                                  : IDX_W'(enq_req_i.tid);
  assign accept = (state_q == IDLE) && req_i && !full_i[tgt];   // Stall while target full

  always_comb begin
    push_o = '0;
    if (accept) push_o[tgt] = 1'b1;              // Exactly one push per handshake
  end
  assign push_burst_o = enq_req_i.burst;
  assign ack_o        = (state_q == ACK);

  // ********************************************************************
  // Handshake FSM
  // ********************************************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = ACK;
      ACK:     if (!req_i) state_d = RELEASE;   // Requester has dropped req
      RELEASE: state_d = IDLE;                  // One quiet cycle before the next req
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) state_q <= IDLE;
    else        state_q <= state_d;
  end

  // Every accepted request pushes exactly one FIFO and is acked next cycle
  a_push_ack: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> $onehot(push_o) ##1 ack_o);

endmodule

/* verilog/bs_req_fifo.sv */
/*
  Request FIFO
  Circular buffer of burst addresses with occupancy count and flags
*/
`timescale 1ns/1ps
`include "bs_macros.svh"

module bs_req_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push_i,
  input  logic [`BS_BURST_W-1:0]  burst_i,
  input  logic                    pop_i,         // Removes head at the edge
  output logic [`BS_BURST_W-1:0]  head_o,
  output bs_pkg::fifo_stat_t      stat_o
);
  localparam int PTR_W = $clog2(`BS_FIFO_DEPTH);

  logic [`BS_BURST_W-1:0]  mem [`BS_FIFO_DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [`BS_CNT_W-1:0]    cnt_q;

  // ********************************************************************
  // Pointers and count
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`BS_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`BS_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;                 // Idle, or push and pop together
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) mem[wr_ptr_q] <= burst_i;
  end

  assign head_o       = mem[rd_ptr_q];           // Valid only while not empty
  assign stat_o.empty = (cnt_q == '0);
  assign stat_o.full  = (cnt_q == `BS_CNT_W'(`BS_FIFO_DEPTH));
  assign stat_o.count = cnt_q;

  // The enqueue port and scheduler must respect the flags
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !stat_o.full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !stat_o.empty);

endmodule

/* verilog/bs_mode_ctrl.sv */
/*
  Mode controller
  Read-first policy with write watermark hysteresis, frozen during a burst
*/
`timescale 1ns/1ps
`include "bs_macros.svh"

module bs_mode_ctrl (
  input  logic                               clk,
  input  logic                               rst_n,
  input  bs_pkg::fifo_stat_t [`BS_FIFOS-1:0] stat_i,
  input  logic                               in_burst_i,  // Mode held while high
  output logic                               wr_mode_o    // 1 = write mode
);
  localparam int OCC_W = $clog2(`BS_WR_FIFOS * `BS_FIFO_DEPTH + 1);

  logic [OCC_W-1:0]  wr_occ;                     // Total write occupancy
  logic              rd_pending;
  logic              wr_any;
  logic              hi_q, hi_d;                 // Watermark reached, not yet drained
  logic              wr_mode_q, wr_mode_d;

  // ********************************************************************
  // Occupancy
  // ********************************************************************
  always_comb begin
    wr_occ     = '0;
    rd_pending = 1'b0;
    for (int k = 0; k < `BS_RD_FIFOS; k++)
      rd_pending = rd_pending | !stat_i[k].empty;
    for (int k = 0; k < `BS_WR_FIFOS; k++)
      wr_occ = wr_occ + OCC_W'(stat_i[`BS_RD_FIFOS + k].count);
  end
  assign wr_any = (wr_occ != '0);

  // Hysteresis between the two watermarks
  always_comb begin
    hi_d = hi_q;
    if (wr_occ >= OCC_W'(`BS_HIGH_WM))     hi_d = 1'b1;
    else if (wr_occ <= OCC_W'(`BS_LOW_WM)) hi_d = 1'b0;
  end

  // Writes also run when nothing else is waiting
  always_comb begin
    wr_mode_d = wr_mode_q;
    if (!in_burst_i)
      wr_mode_d = hi_d || (!rd_pending && wr_any);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hi_q      <= 1'b0;
      wr_mode_q <= 1'b0;                         // Start in read mode
    end else begin
      hi_q      <= hi_d;
      wr_mode_q <= wr_mode_d;
    end
  end

  assign wr_mode_o = wr_mode_q;

endmodule

/* verilog/bs_burst_sched.sv */
/*
  Burst scheduler
  Drains the lowest non-empty FIFO of the active kind, then keeps issuing
  heads of the same kind that hit the current burst address
*/
`timescale 1ns/1ps
`include "bs_macros.svh"

module bs_burst_sched (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   wr_mode_i,
  input  bs_pkg::fifo_stat_t [`BS_FIFOS-1:0]     stat_i,
  input  logic [`BS_FIFOS-1:0][`BS_BURST_W-1:0]  head_i,
  input  logic                                   ready_i,     // Arbiter ready
  output logic                                   valid_o,
  output bs_pkg::issue_t                         issue_o,
  output logic [`BS_FIFOS-1:0]                   pop_o,       // One-hot, on transfer
  output logic                                   in_burst_o
);
  localparam int IDX_W = $clog2(`BS_FIFOS);
  localparam logic [`BS_FIFOS-1:0] RD_MASK = `BS_FIFOS'((1 << `BS_RD_FIFOS) - 1);
  localparam logic [`BS_FIFOS-1:0] WR_MASK = ~RD_MASK;

  typedef enum logic [2:0] {EMPTY, WAITING, RD_BURST, WR_BURST, FINISH} state_e;

  state_e                  state_q, state_d;
  logic                    kind_q, kind_d;       // Kind of the running burst, 1 = write
  logic [`BS_BURST_W-1:0]  cb_q;                 // Current burst address
  logic                    hold_v_q;             // Offer stalled last cycle
  logic [IDX_W-1:0]        hold_idx_q;
  logic [`BS_FIFOS-1:0]    not_empty;
  logic [`BS_FIFOS-1:0]    hits;
  logic [`BS_FIFOS-1:0]    cand;                 // Eligible FIFOs this cycle
  logic [IDX_W-1:0]        sel;
  logic                    new_avail;
  logic                    xfer;

  // Lowest set bit wins
  function automatic logic [IDX_W-1:0] lowest_idx(input logic [`BS_FIFOS-1:0] vec);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int k = `BS_FIFOS - 1; k >= 0; k--)
      if (vec[k]) idx = IDX_W'(k);
    return idx;
  endfunction

  // ********************************************************************
  // Hit detection and selection
  // ********************************************************************
  always_comb begin
    for (int k = 0; k < `BS_FIFOS; k++) begin
      not_empty[k] = !stat_i[k].empty;
      hits[k]      = not_empty[k] && (head_i[k] == cb_q);   // Row hit on a live head
    end
  end

  // Kind requested by the mode controller has work
  assign new_avail = |(not_empty & (wr_mode_i ? WR_MASK : RD_MASK));

  // First pick takes any head, later picks only hits, both within the kind
  assign cand = ((state_q == WAITING) ? not_empty : hits) & (kind_q ? WR_MASK : RD_MASK);
  assign sel  = hold_v_q ? hold_idx_q : lowest_idx(cand);   // Keep the offer under stall

  assign in_burst_o = (state_q == WAITING) || (state_q == RD_BURST) || (state_q == WR_BURST);
  assign valid_o    = in_burst_o && (|cand);
  assign xfer       = valid_o && ready_i;

  always_comb begin
    pop_o = '0;
    if (xfer) pop_o[sel] = 1'b1;
  end

  assign issue_o.burst    = head_i[sel];
  assign issue_o.fifo_idx = sel;
  assign issue_o.is_write = kind_q;

  // ********************************************************************
  // FSM
  // ********************************************************************
  always_comb begin
    state_d = state_q;
    kind_d  = kind_q;
    case (state_q)
      EMPTY, FINISH: begin
        if (new_avail) begin
          state_d = WAITING;
          kind_d  = wr_mode_i;                   // Latch kind for the whole burst
        end else begin
          state_d = EMPTY;
        end
      end
      WAITING:  if (xfer) state_d = kind_q ? WR_BURST : RD_BURST;
      RD_BURST, WR_BURST: begin
        if (!valid_o) state_d = FINISH;          // No more hits, burst ends
      end
      default:  state_d = EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= EMPTY;
      kind_q   <= 1'b0;
      hold_v_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      kind_q   <= kind_d;
      hold_v_q <= valid_o && !ready_i;
    end
  end

  // Burst address taken from the opening transfer
  always_ff @(posedge clk) begin
    hold_idx_q <= sel;
    if ((state_q == WAITING) && xfer) cb_q <= head_i[sel];
  end

  // A pop only ever removes the head of an eligible FIFO
  a_pop_on_xfer: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(pop_o) && ((pop_o != '0) == xfer) && ((pop_o & ~cand) == '0));
  // Back-pressure holds the offer unchanged
  a_hold_offer: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> valid_o && $stable(issue_o));

endmodule

/* verilog/bs_top.sv */
/*
  Bank scheduler subsystem
  Enqueue port, seven request FIFOs, mode controller and burst scheduler
*/
`timescale 1ns/1ps
`include "bs_macros.svh"

module bs_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,
  input  bs_pkg::req_t    enq_req_i,
  output logic            ack_o,
  input  logic            ready_i,
  output logic            valid_o,
  output bs_pkg::issue_t  issue_o
);
  bs_pkg::fifo_stat_t [`BS_FIFOS-1:0]     stat;
  logic [`BS_FIFOS-1:0][`BS_BURST_W-1:0]  head;
  logic [`BS_FIFOS-1:0]                   full;
  logic [`BS_FIFOS-1:0]                   push;
  logic [`BS_FIFOS-1:0]                   pop;
  logic [`BS_BURST_W-1:0]                 push_burst;
  logic                                   wr_mode;
  logic                                   in_burst;

  // ********************************************************************
  // Enqueue side
  // ********************************************************************
  bs_enq_port u_enq_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .enq_req_i    (enq_req_i),
    .full_i       (full),
    .ack_o        (ack_o),
    .push_o       (push),
    .push_burst_o (push_burst)
  );

  // Reads at 0..3, writes above
  for (genvar g = 0; g < `BS_FIFOS; g++) begin : g_fifo
    assign full[g] = stat[g].full;
    bs_req_fifo u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_i  (push[g]),
      .burst_i (push_burst),
      .pop_i   (pop[g]),
      .head_o  (head[g]),
      .stat_o  (stat[g])
    );
  end

  // ********************************************************************
  // Scheduling side
  // ********************************************************************
  bs_mode_ctrl u_mode_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_i     (stat),
    .in_burst_i (in_burst),
    .wr_mode_o  (wr_mode)
  );

  bs_burst_sched u_sched (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_mode_i  (wr_mode),
    .stat_i     (stat),
    .head_i     (head),
    .ready_i    (ready_i),
    .valid_o    (valid_o),
    .issue_o    (issue_o),
    .pop_o      (pop),
    .in_burst_o (in_burst)
  );

endmodule

/* tests/bs_tb.sv */
/*
  Bank scheduler testbench
  Random four-phase requests, random arbiter back-pressure and a cycle model
  of the mode controller and burst scheduler
*/
`timescale 1ns/1ps
`include "bs_macros.svh"

module bs_tb;
  localparam int N_REQ    = 200;
  localparam int N_DIR    = 12;                  // Requests of the watermark phase
  localparam int CLK_NS   = 4;
  localparam int ACK_WAIT = 100;                 // Cycles allowed for one handshake

  typedef enum {M_IDLE, M_OPEN, M_BURST} mstate_e;  // EMPTY/FINISH, WAITING, burst

  logic            clk;
  logic            rst_n;
  logic            req_i;
  bs_pkg::req_t    enq_req_i;
  logic            ack_o;
  logic            ready_i;
  logic            valid_o;
  bs_pkg::issue_t  issue_o;

  integer          seed = 16;
  integer          rdy_seed;                     // Separate stream for back-pressure
  bit              rdy_hold;                     // Arbiter fully stalled while set
  int              errors;
  int              sent;
  int              issued;

  // ********************************************************************
  // Reference model state
  // ********************************************************************
  logic [`BS_BURST_W-1:0]  q [`BS_FIFOS][$];     // Expected contents, head at index 0
  logic [`BS_BURST_W-1:0]  pool [4];             // Few addresses so row hits happen
  mstate_e                 m_state;
  logic                    m_kind;               // Kind of the running burst
  logic                    m_mode;               // Registered mode, 1 = write
  logic                    m_hi;                 // High watermark seen, not yet drained
  logic                    m_held;               // Offer stalled at the last edge
  logic [`BS_BURST_W-1:0]  m_cur;                // Burst address of the open burst
  int                      m_sel;

  bs_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req_i),
    .enq_req_i (enq_req_i),
    .ack_o     (ack_o),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .issue_o   (issue_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic bit has_work(input logic kind);
    bit any;
    any = 1'b0;
    for (int k = 0; k < `BS_FIFOS; k++)
      if (((k >= `BS_RD_FIFOS) == kind) && (q[k].size() != 0)) any = 1'b1;
    return any;
  endfunction

  // Expected source FIFO, -1 when nothing may be offered
  function automatic int expected_sel();
    int pick;
    pick = -1;
    if (m_state == M_IDLE) return -1;
    if (m_held) return m_sel;                    // Stalled offer stays put
    for (int k = `BS_FIFOS - 1; k >= 0; k--)
      if (((k >= `BS_RD_FIFOS) == m_kind) && (q[k].size() != 0) &&
          ((m_state == M_OPEN) || (q[k][0] == m_cur)))
        pick = k;                                // Lowest eligible index wins
    return pick;
  endfunction

  // ********************************************************************
  // Compare one cycle, then advance the model past the rising edge
  // ********************************************************************
  task automatic step_model();
    int                      sel;
    int                      wr_occ;
    bit                      rd_pend;
    bit                      in_burst;
    logic [`BS_BURST_W-1:0]  head;
    sel     = expected_sel();
    wr_occ  = 0;
    rd_pend = 1'b0;
    head    = '0;
    for (int k = 0; k < `BS_FIFOS; k++) begin
      if (k < `BS_RD_FIFOS) rd_pend = rd_pend | (q[k].size() != 0);
      else                  wr_occ  = wr_occ + q[k].size();
    end
    in_burst = (m_state != M_IDLE);

    check_value("valid_o", valid_o, sel >= 0);
    if (sel >= 0) begin
      head = q[sel][0];
      check_value("issue_o.fifo_idx", issue_o.fifo_idx, sel);
      check_value("issue_o.burst", issue_o.burst, head);
      check_value("issue_o.is_write", issue_o.is_write, m_kind);
    end

    if (wr_occ >= `BS_HIGH_WM)     m_hi = 1'b1;
    else if (wr_occ <= `BS_LOW_WM) m_hi = 1'b0;
    case (m_state)
      M_IDLE: begin
        if (has_work(m_mode)) begin              // Kind from the mode before this edge
          m_state = M_OPEN;
          m_kind  = m_mode;
        end
      end
      M_OPEN: begin
        if ((sel >= 0) && ready_i) begin         // Opening transfer sets the burst
          m_cur   = head;
          m_state = M_BURST;
        end
      end
      default: if (sel < 0) m_state = M_IDLE;    // No hit left, burst over
    endcase
    if (!in_burst) m_mode = m_hi || (!rd_pend && (wr_occ != 0));   // Frozen in a burst
    if ((sel >= 0) && ready_i) begin
      void'(q[sel].pop_front());
      issued++;
    end
    m_held = (sel >= 0) && !ready_i;
    m_sel  = sel;
  endtask

  always @(posedge clk) begin
    if (rst_n) step_model();
  end

  // Arbiter model, ready three cycles in four unless stalled
  always @(negedge clk) begin
    if (rst_n) ready_i = !rdy_hold && (($random(rdy_seed) & 3) != 0);
  end

  // Four-phase request; the model learns the push once ack is seen
  task automatic send_request(input logic is_write, input int tid,
                              input logic [`BS_BURST_W-1:0] burst);
    int wait_cyc;
    enq_req_i.is_write = is_write;
    enq_req_i.tid      = 2'(tid);
    enq_req_i.burst    = burst;
    req_i              = 1'b1;
    wait_cyc           = 0;
    do begin
      @(negedge clk);
      wait_cyc++;
    end while (!ack_o && (wait_cyc < ACK_WAIT));
    if (!ack_o) begin
      errors++;
      $display("request %0d was never acknowledged at %0t", sent, $time);
    end else begin
      q[is_write ? `BS_RD_FIFOS + tid : tid].push_back(burst);
      sent++;
    end
    req_i = 1'b0;
    @(negedge clk);
    check_value("ack_o", ack_o, 1'b0);           // Ack drops one cycle after req
  endtask

  // ********************************************************************
  // Stimulus
  // ********************************************************************
  initial begin
    int    rnd;
    logic  is_wr;
    int    tid;
    rst_n     = 1'b0;
    req_i     = 1'b0;
    enq_req_i = '0;
    ready_i   = 1'b0;
    rdy_seed  = seed * 7;
    rdy_hold  = 1'b0;
    errors    = 0;
    sent      = 0;
    issued    = 0;
    m_state   = M_IDLE;
    m_kind    = 1'b0;
    m_mode    = 1'b0;
    m_hi      = 1'b0;
    m_held    = 1'b0;
    m_cur     = '0;
    m_sel     = -1;
    pool[0]   = 16'h0a10;
    pool[1]   = 16'h0a11;
    pool[2]   = 16'h3c20;
    pool[3]   = 16'hf0e1;
    repeat (2) @(negedge clk);
    check_value("valid_o", valid_o, 1'b0);
    check_value("ack_o", ack_o, 1'b0);
    rst_n = 1'b1;

    for (int n = 0; n < N_REQ; n++) begin
      rnd   = $random(seed);
      is_wr = rnd[0];
      tid   = is_wr ? (rnd[3:2] % `BS_WR_FIFOS) : rnd[3:2];   // Writes use ids 0..2
      send_request(is_wr, tid, pool[rnd[5:4]]);
      if (rnd[8:6] == 3'd0) repeat (rnd[11:9]) @(negedge clk);   // Occasional quiet gap
    end
    while (issued != sent) @(negedge clk);       // Drain, watchdog bounds this

    // Writes pile up behind stalled reads past the high watermark
    @(posedge clk);
    rdy_hold = 1'b1;
    @(negedge clk);
    for (int n = 0; n < N_DIR; n++) begin
      if (n < 3) send_request(1'b0, 0, pool[n + 1]);       // Reads on distinct rows
      else       send_request(1'b1, n % `BS_WR_FIFOS, pool[n % 4]);
    end
    @(posedge clk);
    rdy_hold = 1'b0;
    @(negedge clk);
    while (issued != sent) @(negedge clk);
    repeat (4) @(negedge clk);

    $display("errors: %0d, requests sent: %0d, issued: %0d", errors, sent, issued);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Generous bound per request, covering stalls and write-mode waits
  initial begin
    #((N_REQ + N_DIR) * 40 * CLK_NS);
    $display("timeout, only %0d of %0d requests issued", issued, sent);
    $display("errors: %0d, requests sent: %0d, issued: %0d", errors + 1, sent, issued);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/bs_pkg.sv
verilog/bs_enq_port.sv
verilog/bs_req_fifo.sv
verilog/bs_mode_ctrl.sv
verilog/bs_burst_sched.sv
verilog/bs_top.sv
tests/bs_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module bs_tb \
  -o bs_sim || { echo "build failed"; exit 1; }
./obj_dir/bs_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
